// ==== sim.f ====
+incdir+logic
logic/csr_pkg.sv
logic/csr_trap_ctrl.sv
logic/csr_regfile.sv
logic/csr_commit.sv
logic/csr_unit.sv
dv/csr_unit_properties.sv
dv/csr_unit_tb.sv

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_unit_tb;

  localparam int clk_period_lp   = 4;
  localparam int reset_cycles_lp = 8;
  // Cycle budget of the six tests
  localparam int test_cycles_lp  = 10 + 25 + 15 + 30 + 20 + 15;
  localparam int timeout_lp      = (test_cycles_lp * 2 + reset_cycles_lp) * clk_period_lp;
  localparam logic [63:0] mstatus_mask_lp = 64'h1888;
  localparam logic [63:0] trap_vec_lp     = 64'h0000_0000_8000_1000;

  logic                    clk, arst_n, csr_cmd_v, retire_v, interrupt_v;
  logic                    timer_irq, software_irq, external_irq, interrupt_ready;
  csr_pkg::csr_cmd_s       csr_cmd;
  csr_pkg::exc_s           exc;
  csr_pkg::commit_pkt_s    commit_pkt;
  logic [31:0]             instr;
  logic [`CSR_VADDR_W-1:0] npc, vaddr;
  logic [`CSR_XLEN-1:0]    csr_data;

  // Reference model
  logic [`CSR_VADDR_W-1:0] m_apc;
  csr_pkg::priv_e          m_priv;
  logic [`CSR_XLEN-1:0]    m_mstatus, m_mtvec, m_mscratch, m_mepc, m_minstret;
  logic                    m_inhibit;

  csr_unit #(.hart_id_p(5)) dut_i
    (.clk_i(clk)
     ,.arst_n_i(arst_n)
     ,.csr_cmd_v_i(csr_cmd_v)
     ,.csr_cmd_i(csr_cmd)
     ,.csr_data_o(csr_data)
     ,.retire_v_i(retire_v)
     ,.exc_i(exc)
     ,.instr_i(instr)
     ,.npc_i(npc)
     ,.vaddr_i(vaddr)
     ,.timer_irq_i(timer_irq)
     ,.software_irq_i(software_irq)
     ,.external_irq_i(external_irq)
     ,.interrupt_v_i(interrupt_v)
     ,.interrupt_ready_o(interrupt_ready)
     ,.commit_pkt_o(commit_pkt)
     );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period_lp / 2) clk = ~clk;
  end

  initial
  begin
    #(timeout_lp);
    $display("ERROR: watchdog expired at %0t, the tests did not finish", $time);
    $display("TB FAILED");
    $fatal(1, "watchdog timeout");
  end

  always @(dut_i.props_i.fail_cnt)
  begin
    if (dut_i.props_i.fail_cnt != 0)
    begin
      $display("ERROR: a bound assertion failed at %0t", $time);
      $display("TB FAILED");
      $fatal(1, "assertion failure");
    end
  end

  task automatic check_data(input string name, input logic [`CSR_XLEN-1:0] exp,
                            input logic [`CSR_XLEN-1:0] act);
    if (exp !== act)
    begin
      $display("CHECK FAILED time=%0t %s exp=%h act=%h", $time, name, exp, act);
      $display("TB FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_commit(input string name, input csr_pkg::commit_pkt_s exp,
                              input csr_pkg::commit_pkt_s act);
    if (exp !== act)
    begin
      $display("CHECK FAILED time=%0t %s exp=%h act=%h", $time, name, exp, act);
      $display("TB FAILED");
      $fatal(1, "commit packet mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("CHECK FAILED time=%0t %s exp=%b act=%b", $time, name, exp, act);
      $display("TB FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  function automatic logic [63:0] apply_op(input csr_pkg::csr_op_e op,
                                           input logic [63:0] old, input logic [63:0] data);
    logic [63:0] imm;
    imm = {59'd0, data[4:0]};
    case (op)
      csr_pkg::e_csrrw:  return data;
      csr_pkg::e_csrrs:  return old | data;
      csr_pkg::e_csrrc:  return old & ~data;
      csr_pkg::e_csrrwi: return imm;
      csr_pkg::e_csrrsi: return old | imm;
      csr_pkg::e_csrrci: return old & ~imm;
      default:           return old;
    endcase
  endfunction

  task automatic next_cycle;
    @(posedge clk);
    #1;
    csr_cmd_v   = 1'b0;
    retire_v    = 1'b0;
    interrupt_v = 1'b0;
    csr_cmd     = '0;
    exc         = '0;
    instr       = '0;
  endtask

  task automatic drive_csr(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                           input logic [63:0] data, input logic [31:0] ins);
    csr_cmd_v        = 1'b1;
    retire_v         = 1'b1;
    csr_cmd.op       = op;
    csr_cmd.addr.raw = addr;
    csr_cmd.data     = data;
    instr            = ins;
    npc              = m_apc + 39'd4;
    #1;
  endtask

  task automatic drive_retire(input csr_pkg::exc_s e, input logic [31:0] ins);
    retire_v = 1'b1;
    exc      = e;
    instr    = ins;
    npc      = m_apc + 39'd4;
    #1;
  endtask

  // Checks the packet and advances the model
  task automatic expect_commit(input logic v, input logic ret,
                               input logic [`CSR_VADDR_W-1:0] exp_npc,
                               input csr_pkg::priv_e p_n, input logic exc_f,
                               input logic irq_f, input logic eret_f);
    csr_pkg::commit_pkt_s exp;
    exp           = '0;
    exp.v         = v;
    exp.instret   = ret;
    exp.pc        = m_apc;
    exp.npc       = exp_npc;
    exp.priv_n    = p_n;
    exp.exception = exc_f;
    exp.interrupt = irq_f;
    exp.eret      = eret_f;
    exp.instr     = instr;
    check_commit("commit_pkt", exp, commit_pkt);
    if (ret && !m_inhibit)
      m_minstret = m_minstret + 64'd1;
    m_apc  = exp_npc;
    m_priv = p_n;
  endtask

  task automatic expect_trap(input logic irq_f);
    m_mepc             = {25'd0, m_apc};
    m_mstatus[12:11]   = m_priv;
    m_mstatus[7]       = m_mstatus[3];
    m_mstatus[3]       = 1'b0;
    expect_commit(1'b1, 1'b0, {m_mtvec[`CSR_VADDR_W-1:2], 2'b00}, csr_pkg::e_priv_m,
                  !irq_f, irq_f, 1'b0);
  endtask

  task automatic csr_issue(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                           input logic [63:0] data, output logic [63:0] old);
    drive_csr(op, addr, data, {addr, 20'h02573});
    old = csr_data;
    expect_commit(1'b0, 1'b1, m_apc + 39'd4, m_priv, 1'b0, 1'b0, 1'b0);
    next_cycle;
  endtask

  task automatic check_mcause(input logic irq_f, input logic [3:0] code);
    logic [63:0] val;
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MCAUSE, 64'd0, val);
    check_data("mcause", {irq_f, 59'd0, code}, val);
  endtask

  task automatic do_mret;
    csr_pkg::priv_e p;
    drive_csr(csr_pkg::e_mret, 12'h000, 64'd0, 32'h3020_0073);
    p                = csr_pkg::priv_e'(m_mstatus[12:11]);
    m_mstatus[3]     = m_mstatus[7];
    m_mstatus[7]     = 1'b1;
    m_mstatus[12:11] = 2'b00;
    expect_commit(1'b1, 1'b1, m_mepc[`CSR_VADDR_W-1:0], p, 1'b0, 1'b0, 1'b1);
    next_cycle;
  endtask

  task automatic test_reset_identity;
    logic [63:0] val;
    check_bit("interrupt_ready_o", 1'b0, interrupt_ready);
    check_bit("commit_pkt_o.v", 1'b0, commit_pkt.v);
    // First retire carries the boot PC
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MISA, 64'd0, val);
    check_data("misa", `CSR_MISA_VAL, val);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MHARTID, 64'd0, val);
    check_data("mhartid", 64'd5, val);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MARCHID, 64'd0, val);
    check_data("marchid", `CSR_MARCHID, val);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MIMPID, 64'd0, val);
    check_data("mimpid", `CSR_MIMPID, val);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MSTATUS, 64'd0, val);
    check_data("mstatus", 64'd0, val);
  endtask

  task automatic test_rmw;
    csr_pkg::csr_op_e op;
    logic [63:0]      data, val;
    for (int i = 0; i < 6; i++)
    begin
      op   = csr_pkg::csr_op_e'(i);
      data = {$urandom, $urandom};
      csr_issue(op, `CSR_ADDR_MSCRATCH, data, val);
      check_data("mscratch", m_mscratch, val);
      m_mscratch = apply_op(op, m_mscratch, data);
      data = {$urandom, $urandom};
      csr_issue(op, `CSR_ADDR_MTVEC, data, val);
      check_data("mtvec", m_mtvec, val);
      m_mtvec = apply_op(op, m_mtvec, data);
    end
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MSCRATCH, 64'd0, val);
    check_data("mscratch", m_mscratch, val);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MTVEC, 64'd0, val);
    check_data("mtvec", m_mtvec, val);
    // mpp kept to U or M
    data     = {$urandom, $urandom};
    data[12] = data[11];
    csr_issue(csr_pkg::e_csrrw, `CSR_ADDR_MSTATUS, data, val);
    check_data("mstatus", m_mstatus, val);
    m_mstatus = data & mstatus_mask_lp;
    csr_issue(csr_pkg::e_csrrw, `CSR_ADDR_MSTATUS, 64'd0, val);
    check_data("mstatus", m_mstatus, val);
    m_mstatus = '0;
  endtask

  task automatic test_trap_return;
    csr_pkg::exc_s e;
    logic [63:0]   val;
    csr_issue(csr_pkg::e_csrrw, `CSR_ADDR_MTVEC, trap_vec_lp, val);
    check_data("mtvec", m_mtvec, val);
    m_mtvec = trap_vec_lp;
    e       = '0;
    e.ecall = 1'b1;
    drive_retire(e, 32'h0000_0073);
    expect_trap(1'b0);
    next_cycle;
    check_mcause(1'b0, 4'd11);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MEPC, 64'd0, val);
    check_data("mepc", m_mepc, val);
    csr_issue(csr_pkg::e_csrrc, `CSR_ADDR_MSTATUS, 64'h1800, val);
    check_data("mstatus", m_mstatus, val);
    m_mstatus = m_mstatus & ~64'h1800;
    do_mret;
  endtask

  task automatic test_user_checks;
    csr_pkg::exc_s e;
    logic [63:0]   val;
    drive_csr(csr_pkg::e_csrrs, `CSR_ADDR_MSTATUS, 64'd0, 32'h3000_2573);
    expect_trap(1'b0);
    next_cycle;
    check_mcause(1'b0, 4'd2);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MTVAL, 64'd0, val);
    check_data("mtval", 64'h3000_2573, val);
    do_mret;
    // cycle is hidden from U until mcounteren.cy is set
    drive_csr(csr_pkg::e_csrrs, `CSR_ADDR_CYCLE, 64'd0, 32'hC000_2573);
    expect_trap(1'b0);
    next_cycle;
    check_mcause(1'b0, 4'd2);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MCOUNTEREN, 64'd1, val);
    check_data("mcounteren", 64'd0, val);
    do_mret;
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_CYCLE, 64'd0, val);
    check_bit("cycle_nonzero", 1'b1, val != 64'd0);
    e       = '0;
    e.ecall = 1'b1;
    drive_retire(e, 32'h0000_0073);
    expect_trap(1'b0);
    next_cycle;
    check_mcause(1'b0, 4'd8);
  endtask

  task automatic test_interrupts;
    logic [63:0] val;
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MIE, 64'h88, val);
    check_data("mie", 64'd0, val);
    timer_irq    = 1'b1;
    software_irq = 1'b1;
    next_cycle;
    #1;
    check_bit("interrupt_ready_o", 1'b0, interrupt_ready);
    timer_irq    = 1'b0;
    software_irq = 1'b0;
    next_cycle;
    do_mret;
    check_bit("interrupt_ready_o", 1'b0, interrupt_ready);
    timer_irq    = 1'b1;
    software_irq = 1'b1;
    #1;
    check_bit("interrupt_ready_o", 1'b0, interrupt_ready);
    next_cycle;
    interrupt_v = 1'b1;
    #1;
    check_bit("interrupt_ready_o", 1'b1, interrupt_ready);
    // msi has the lowest code
    expect_trap(1'b1);
    next_cycle;
    timer_irq    = 1'b0;
    software_irq = 1'b0;
    check_mcause(1'b1, 4'd3);
  endtask

  task automatic test_counters;
    logic [63:0] val, exp, c1, c2;
    // Read-only user views leave the counters running
    exp = m_minstret;
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_INSTRET, 64'd0, val);
    check_data("instret", exp, val);
    repeat (3)
    begin
      csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MSCRATCH, 64'd0, val);
      check_data("mscratch", m_mscratch, val);
    end
    exp = m_minstret;
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_INSTRET, 64'd0, val);
    check_data("instret", exp, val);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MCOUNTINHIBIT, 64'd4, val);
    check_data("mcountinhibit", 64'd0, val);
    m_inhibit = 1'b1;
    exp       = m_minstret;
    repeat (3)
      csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_MSCRATCH, 64'd0, val);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_INSTRET, 64'd0, val);
    check_data("instret", exp, val);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_CYCLE, 64'd0, c1);
    csr_issue(csr_pkg::e_csrrs, `CSR_ADDR_CYCLE, 64'd0, c2);
    check_data("cycle", c1 + 64'd1, c2);
  endtask

  initial
  begin
    void'($urandom(13));
    arst_n       = 1'b0;
    csr_cmd_v    = 1'b0;
    csr_cmd      = '0;
    retire_v     = 1'b0;
    exc          = '0;
    instr        = '0;
    npc          = '0;
    vaddr        = '0;
    timer_irq    = 1'b0;
    software_irq = 1'b0;
    external_irq = 1'b0;
    interrupt_v  = 1'b0;
    m_apc        = `CSR_BOOT_PC;
    m_priv       = csr_pkg::e_priv_m;
    m_mstatus    = '0;
    m_mtvec      = '0;
    m_mscratch   = '0;
    m_mepc       = '0;
    m_minstret   = '0;
    m_inhibit    = 1'b0;
    repeat (reset_cycles_lp) @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_reset_identity();
    test_rmw();
    test_trap_return();
    test_user_checks();
    test_interrupts();
    test_counters();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/csr_unit_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_properties
  (input  logic                   clk_i
   , input logic                  arst_n_i
   , input csr_pkg::commit_pkt_s  commit_pkt_i
   );

  int unsigned fail_cnt = 0;

  a_single_trap_kind: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                       !(commit_pkt_i.exception && commit_pkt_i.interrupt))
    else
    begin
      $error("commit packet flags exception and interrupt together");
      fail_cnt++;
    end

  a_eret_no_trap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                   commit_pkt_i.eret |-> !(commit_pkt_i.exception
                                                           || commit_pkt_i.interrupt))
    else
    begin
      $error("eret committed together with a trap");
      fail_cnt++;
    end

  a_priv_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 commit_pkt_i.priv_n inside {csr_pkg::e_priv_u,
                                                             csr_pkg::e_priv_m})
    else
    begin
      $error("priv_n is neither U nor M");
      fail_cnt++;
    end

endmodule

bind csr_unit csr_unit_properties props_i
  (.clk_i(clk_i)
   ,.arst_n_i(arst_n_i)
   ,.commit_pkt_i(commit_pkt_o)
   );

`default_nettype wire

// ==== logic/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_unit
  #(parameter int unsigned hart_id_p = 0)
  (input  logic                       clk_i
   , input logic                      arst_n_i

   , input logic                      csr_cmd_v_i
   , input csr_pkg::csr_cmd_s         csr_cmd_i
   , output logic [`CSR_XLEN-1:0]     csr_data_o

   , input logic                      retire_v_i
   , input csr_pkg::exc_s             exc_i
   , input logic [31:0]               instr_i
   , input logic [`CSR_VADDR_W-1:0]   npc_i
   , input logic [`CSR_VADDR_W-1:0]   vaddr_i

   , input logic                      timer_irq_i
   , input logic                      software_irq_i
   , input logic                      external_irq_i
   , input logic                      interrupt_v_i
   , output logic                     interrupt_ready_o

   , output csr_pkg::commit_pkt_s     commit_pkt_o
   );

  logic                    illegal, mret, instret;
  csr_pkg::priv_e          priv, priv_n;
  csr_pkg::mstatus_s       mstatus;
  csr_pkg::irq_bits_s      mie, mip;
  csr_pkg::trap_s          trap;
  logic [`CSR_VADDR_W-1:0] mtvec, mepc, apc;

  csr_trap_ctrl trap_ctrl_i
    (.retire_v_i(retire_v_i)
     ,.exc_i(exc_i)
     ,.illegal_i(illegal)
     ,.priv_i(priv)
     ,.mstatus_i(mstatus)
     ,.mie_i(mie)
     ,.mip_i(mip)
     ,.interrupt_v_i(interrupt_v_i)
     ,.trap_o(trap)
     ,.interrupt_ready_o(interrupt_ready_o)
     );

  csr_regfile #(.hart_id_p(hart_id_p)) regfile_i
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.csr_cmd_v_i(csr_cmd_v_i)
     ,.csr_cmd_i(csr_cmd_i)
     ,.retire_v_i(retire_v_i)
     ,.instr_i(instr_i)
     ,.vaddr_i(vaddr_i)
     ,.timer_irq_i(timer_irq_i)
     ,.software_irq_i(software_irq_i)
     ,.external_irq_i(external_irq_i)
     ,.trap_i(trap)
     ,.apc_i(apc)
     ,.instret_i(instret)
     ,.csr_data_o(csr_data_o)
     ,.illegal_o(illegal)
     ,.mret_o(mret)
     ,.priv_o(priv)
     ,.priv_n_o(priv_n)
     ,.mstatus_o(mstatus)
     ,.mie_o(mie)
     ,.mip_o(mip)
     ,.mtvec_o(mtvec)
     ,.mepc_o(mepc)
     );

  csr_commit commit_i
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.retire_v_i(retire_v_i)
     ,.npc_i(npc_i)
     ,.instr_i(instr_i)
     ,.trap_i(trap)
     ,.mret_i(mret)
     ,.mtvec_i(mtvec)
     ,.mepc_i(mepc)
     ,.priv_n_i(priv_n)
     ,.apc_o(apc)
     ,.instret_o(instret)
     ,.commit_pkt_o(commit_pkt_o)
     );

endmodule

`default_nettype wire

// ==== logic/csr_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_commit
  (input  logic                       clk_i
   , input logic                      arst_n_i

   , input logic                      retire_v_i
   , input logic [`CSR_VADDR_W-1:0]   npc_i
   , input logic [31:0]               instr_i
   , input csr_pkg::trap_s            trap_i
   , input logic                      mret_i
   , input logic [`CSR_VADDR_W-1:0]   mtvec_i
   , input logic [`CSR_VADDR_W-1:0]   mepc_i
   , input csr_pkg::priv_e            priv_n_i

   , output logic [`CSR_VADDR_W-1:0]  apc_o
   , output logic                     instret_o
   , output csr_pkg::commit_pkt_s     commit_pkt_o
   );

  logic [`CSR_VADDR_W-1:0] apc_r, apc_n;
  logic                    eret;

  // A trap in the same cycle wins over mret
  assign eret      = mret_i & ~trap_i.v;
  assign instret_o = retire_v_i & ~trap_i.v;

  always_comb
  begin
    if (eret)
      apc_n = mepc_i;
    else if (trap_i.v)
      apc_n = {mtvec_i[`CSR_VADDR_W-1:2], 2'b00};
    else if (instret_o)
      apc_n = npc_i;
    else
      apc_n = apc_r;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      apc_r <= `CSR_BOOT_PC;
    else
      apc_r <= apc_n;
  end

  assign apc_o = apc_r;

  always_comb
  begin
    commit_pkt_o           = '0;
    commit_pkt_o.v         = trap_i.v | eret;
    commit_pkt_o.instret   = instret_o;
    commit_pkt_o.pc        = apc_r;
    commit_pkt_o.npc       = apc_n;
    commit_pkt_o.priv_n    = priv_n_i;
    commit_pkt_o.exception = trap_i.v & ~trap_i.interrupt;
    commit_pkt_o.interrupt = trap_i.v & trap_i.interrupt;
    commit_pkt_o.eret      = eret;
    commit_pkt_o.instr     = instr_i;
  end

endmodule

`default_nettype wire

// ==== logic/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_regfile
  #(parameter int unsigned hart_id_p = 0)
  (input  logic                       clk_i
   , input logic                      arst_n_i

   , input logic                      csr_cmd_v_i
   , input csr_pkg::csr_cmd_s         csr_cmd_i
   , input logic                      retire_v_i
   , input logic [31:0]               instr_i
   , input logic [`CSR_VADDR_W-1:0]   vaddr_i

   , input logic                      timer_irq_i
   , input logic                      software_irq_i
   , input logic                      external_irq_i

   , input csr_pkg::trap_s            trap_i
   , input logic [`CSR_VADDR_W-1:0]   apc_i
   , input logic                      instret_i

   , output logic [`CSR_XLEN-1:0]     csr_data_o
   , output logic                     illegal_o
   , output logic                     mret_o
   , output csr_pkg::priv_e           priv_o
   , output csr_pkg::priv_e           priv_n_o
   , output csr_pkg::mstatus_s        mstatus_o
   , output csr_pkg::irq_bits_s       mie_o
   , output csr_pkg::irq_bits_s       mip_o
   , output logic [`CSR_VADDR_W-1:0]  mtvec_o
   , output logic [`CSR_VADDR_W-1:0]  mepc_o
   );

  csr_pkg::priv_e     priv_r, priv_n;
  csr_pkg::mstatus_s  mstatus_r, mstatus_n, mstatus_w;
  csr_pkg::irq_bits_s mie_r, mie_n, mie_w, mip_r, mip_n;
  csr_pkg::mcause_s   mcause_r, mcause_n;

  logic [`CSR_XLEN-1:0] mtvec_r, mtvec_n, mscratch_r, mscratch_n;
  logic [`CSR_XLEN-1:0] mepc_r, mepc_n, mtval_r, mtval_n;
  logic [`CSR_XLEN-1:0] mcounteren_r, mcounteren_n, mcountinhibit_r, mcountinhibit_n;
  logic [`CSR_XLEN-1:0] mcycle_r, mcycle_n, minstret_r, minstret_n;

  logic [`CSR_XLEN-1:0] rdata, wdata, imm;
  logic                 cmd_fire, is_mret, addr_known, cnt_denied, do_write;

  assign cmd_fire = csr_cmd_v_i & retire_v_i;
  assign is_mret  = (csr_cmd_i.op == csr_pkg::e_mret);

  // Old value
  always_comb
  begin
    rdata      = '0;
    addr_known = 1'b1;
    case (csr_cmd_i.addr.raw)
      `CSR_ADDR_CYCLE, `CSR_ADDR_MCYCLE:     rdata = mcycle_r;
      `CSR_ADDR_INSTRET, `CSR_ADDR_MINSTRET: rdata = minstret_r;
      `CSR_ADDR_MSTATUS:       rdata = mstatus_r;
      `CSR_ADDR_MISA:          rdata = `CSR_MISA_VAL;
      `CSR_ADDR_MIE:           rdata = mie_r;
      `CSR_ADDR_MTVEC:         rdata = mtvec_r;
      `CSR_ADDR_MCOUNTEREN:    rdata = mcounteren_r;
      `CSR_ADDR_MCOUNTINHIBIT: rdata = mcountinhibit_r;
      `CSR_ADDR_MSCRATCH:      rdata = mscratch_r;
      `CSR_ADDR_MEPC:          rdata = mepc_r;
      `CSR_ADDR_MCAUSE:        rdata = mcause_r;
      `CSR_ADDR_MTVAL:         rdata = mtval_r;
      `CSR_ADDR_MIP:           rdata = mip_r;
      `CSR_ADDR_MVENDORID:     rdata = '0;
      `CSR_ADDR_MARCHID:       rdata = `CSR_MARCHID;
      `CSR_ADDR_MIMPID:        rdata = `CSR_MIMPID;
      `CSR_ADDR_MHARTID:       rdata = `CSR_XLEN'(hart_id_p);
      default:                 addr_known = 1'b0;
    endcase
  end

  // User counter views gated by mcounteren cy and ir
  assign cnt_denied = (priv_r == csr_pkg::e_priv_u)
                      & (((csr_cmd_i.addr.raw == `CSR_ADDR_CYCLE) & ~mcounteren_r[0])
                         | ((csr_cmd_i.addr.raw == `CSR_ADDR_INSTRET) & ~mcounteren_r[2]));

  assign illegal_o = cmd_fire & (is_mret ? (priv_r != csr_pkg::e_priv_m)
                                         : ((priv_r < csr_cmd_i.addr.f.priv)
                                            | cnt_denied | ~addr_known));
  assign mret_o    = cmd_fire & is_mret & (priv_r == csr_pkg::e_priv_m);

  assign imm = `CSR_XLEN'(csr_cmd_i.data[4:0]);

  always_comb
  begin
    case (csr_cmd_i.op)
      csr_pkg::e_csrrw:  wdata = csr_cmd_i.data;
      csr_pkg::e_csrrs:  wdata = rdata | csr_cmd_i.data;
      csr_pkg::e_csrrc:  wdata = rdata & ~csr_cmd_i.data;
      csr_pkg::e_csrrwi: wdata = imm;
      csr_pkg::e_csrrsi: wdata = rdata | imm;
      csr_pkg::e_csrrci: wdata = rdata & ~imm;
      default:           wdata = rdata;
    endcase
  end

  // Access field 2'b11 marks a read-only CSR
  assign do_write  = cmd_fire & ~is_mret & ~trap_i.v & (csr_cmd_i.addr.f.access != 2'b11);
  assign mstatus_w = wdata;
  assign mie_w     = wdata;

  always_comb
  begin
    priv_n          = priv_r;
    mstatus_n       = mstatus_r;
    mie_n           = mie_r;
    mtvec_n         = mtvec_r;
    mscratch_n      = mscratch_r;
    mepc_n          = mepc_r;
    mcause_n        = mcause_r;
    mtval_n         = mtval_r;
    mcounteren_n    = mcounteren_r;
    mcountinhibit_n = mcountinhibit_r;
    mcycle_n        = mcountinhibit_r[0] ? mcycle_r : mcycle_r + `CSR_XLEN'(1);
    minstret_n      = mcountinhibit_r[2] ? minstret_r : minstret_r + `CSR_XLEN'(instret_i);

    mip_n     = '0;
    mip_n.msi = software_irq_i;
    mip_n.mti = timer_irq_i;
    mip_n.mei = external_irq_i;

    if (do_write)
    begin
      case (csr_cmd_i.addr.raw)
        `CSR_ADDR_MSTATUS:
        begin
          mstatus_n      = '0;
          mstatus_n.mie  = mstatus_w.mie;
          mstatus_n.mpie = mstatus_w.mpie;
          // Only U and M are legal previous modes
          mstatus_n.mpp  = (mstatus_w.mpp == csr_pkg::e_priv_m) ? csr_pkg::e_priv_m
                                                                  : csr_pkg::e_priv_u;
        end
        `CSR_ADDR_MIE:
        begin
          mie_n     = '0;
          mie_n.msi = mie_w.msi;
          mie_n.mti = mie_w.mti;
          mie_n.mei = mie_w.mei;
        end
        `CSR_ADDR_MTVEC:         mtvec_n         = wdata;
        `CSR_ADDR_MCOUNTEREN:    mcounteren_n    = wdata;
        `CSR_ADDR_MCOUNTINHIBIT: mcountinhibit_n = wdata;
        `CSR_ADDR_MSCRATCH:      mscratch_n      = wdata;
        `CSR_ADDR_MEPC:          mepc_n          = wdata;
        `CSR_ADDR_MCAUSE:        mcause_n        = wdata;
        `CSR_ADDR_MTVAL:         mtval_n         = wdata;
        `CSR_ADDR_MCYCLE:        mcycle_n        = wdata;
        `CSR_ADDR_MINSTRET:      minstret_n      = wdata;
        default: ;
      endcase
    end

    if (mret_o & ~trap_i.v)
    begin
      priv_n         = mstatus_r.mpp;
      mstatus_n.mie  = mstatus_r.mpie;
      mstatus_n.mpie = 1'b1;
      mstatus_n.mpp  = csr_pkg::e_priv_u;
    end

    if (trap_i.v)
    begin
      priv_n             = csr_pkg::e_priv_m;
      mstatus_n.mpp      = priv_r;
      mstatus_n.mpie     = mstatus_r.mie;
      mstatus_n.mie      = 1'b0;
      mepc_n             = `CSR_XLEN'($signed(apc_i));
      mcause_n           = '0;
      mcause_n.interrupt = trap_i.interrupt;
      mcause_n.ecode     = trap_i.ecode;
      mtval_n            = '0;
      if (!trap_i.interrupt)
      begin
        case (trap_i.ecode)
          `CSR_ECODE_W'(2): mtval_n = `CSR_XLEN'(instr_i);
          // Misaligned and access faults report the faulting address
          `CSR_ECODE_W'(0), `CSR_ECODE_W'(1), `CSR_ECODE_W'(4),
          `CSR_ECODE_W'(5), `CSR_ECODE_W'(6): mtval_n = `CSR_XLEN'($signed(vaddr_i));
          default:          mtval_n = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      priv_r          <= csr_pkg::e_priv_m;
      mstatus_r       <= '0;
      mie_r           <= '0;
      mip_r           <= '0;
      mtvec_r         <= '0;
      mscratch_r      <= '0;
      mepc_r          <= '0;
      mcause_r        <= '0;
      mtval_r         <= '0;
      mcounteren_r    <= '0;
      mcountinhibit_r <= '0;
      mcycle_r        <= '0;
      minstret_r      <= '0;
    end
    else
    begin
      priv_r          <= priv_n;
      mstatus_r       <= mstatus_n;
      mie_r           <= mie_n;
      mip_r           <= mip_n;
      mtvec_r         <= mtvec_n;
      mscratch_r      <= mscratch_n;
      mepc_r          <= mepc_n;
      mcause_r        <= mcause_n;
      mtval_r         <= mtval_n;
      mcounteren_r    <= mcounteren_n;
      mcountinhibit_r <= mcountinhibit_n;
      mcycle_r        <= mcycle_n;
      minstret_r      <= minstret_n;
    end
  end

  assign csr_data_o = rdata;
  assign priv_o     = priv_r;
  assign priv_n_o   = priv_n;
  assign mstatus_o  = mstatus_r;
  assign mie_o      = mie_r;
  assign mip_o      = mip_r;
  assign mtvec_o    = mtvec_r[`CSR_VADDR_W-1:0];
  assign mepc_o     = mepc_r[`CSR_VADDR_W-1:0];

endmodule

`default_nettype wire

// ==== logic/csr_trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_trap_ctrl
  (input  logic                 retire_v_i
   , input csr_pkg::exc_s       exc_i
   , input logic                illegal_i
   , input csr_pkg::priv_e      priv_i
   , input csr_pkg::mstatus_s   mstatus_i
   , input csr_pkg::irq_bits_s  mie_i
   , input csr_pkg::irq_bits_s  mip_i
   , input logic                interrupt_v_i

   , output csr_pkg::trap_s     trap_o
   , output logic               interrupt_ready_o
   );

  localparam int dec_w_lp = 1 << `CSR_ECODE_W;

  logic [dec_w_lp-1:0] exc_dec;
  logic [dec_w_lp-1:0] irq_dec;
  csr_pkg::irq_bits_s  irq_pend;
  logic                mgie;

  // Lowest set code wins
  function automatic logic [`CSR_ECODE_W-1:0] lowest_set(input logic [dec_w_lp-1:0] vec);
    logic [`CSR_ECODE_W-1:0] code;
    code = '0;
    for (int i = dec_w_lp-1; i >= 0; i--)
    begin
      if (vec[i])
        code = `CSR_ECODE_W'(i);
    end
    return code;
  endfunction

  always_comb
  begin
    exc_dec     = '0;
    exc_dec[0]  = exc_i.instr_misaligned;
    exc_dec[1]  = exc_i.instr_access_fault;
    exc_dec[2]  = exc_i.illegal_instr | illegal_i;
    exc_dec[3]  = exc_i.ebreak;
    exc_dec[4]  = exc_i.load_misaligned;
    exc_dec[5]  = exc_i.load_access_fault;
    exc_dec[6]  = exc_i.store_misaligned;
    exc_dec[8]  = exc_i.ecall & (priv_i == csr_pkg::e_priv_u);
    exc_dec[11] = exc_i.ecall & (priv_i == csr_pkg::e_priv_m);
  end

  // U mode is always interruptible by M
  assign mgie     = (priv_i == csr_pkg::e_priv_m) ? mstatus_i.mie : 1'b1;
  assign irq_pend = mie_i & mip_i;

  always_comb
  begin
    irq_dec     = '0;
    irq_dec[3]  = irq_pend.msi & mgie;
    irq_dec[7]  = irq_pend.mti & mgie;
    irq_dec[11] = irq_pend.mei & mgie;
  end

  assign interrupt_ready_o = |irq_dec;

  always_comb
  begin
    trap_o = '0;
    if (interrupt_v_i & interrupt_ready_o)
    begin
      trap_o.v         = 1'b1;
      trap_o.interrupt = 1'b1;
      trap_o.ecode     = lowest_set(irq_dec);
    end
    else if (retire_v_i & (|exc_dec))
    begin
      trap_o.v     = 1'b1;
      trap_o.ecode = lowest_set(exc_dec);
    end
  end

endmodule

`default_nettype wire

// ==== logic/csr_pkg.sv ====
`default_nettype none

`include "csr_defs.svh"

package csr_pkg;

  typedef enum logic [1:0] {
    e_priv_u = 2'b00,
    e_priv_m = 2'b11
  } priv_e;

  typedef enum logic [2:0] {
    e_csrrw,
    e_csrrs,
    e_csrrc,
    e_csrrwi,
    e_csrrsi,
    e_csrrci,
    e_mret
  } csr_op_e;

  typedef struct packed {
    logic [1:0] access;
    logic [1:0] priv;
    logic [7:0] index;
  } csr_addr_fields_s;

  // Same 12 bits, seen as a raw address or as its encoded fields
  typedef union packed {
    logic [11:0]      raw;
    csr_addr_fields_s f;
  } csr_addr_u;

  typedef struct packed {
    csr_op_e                op;
    csr_addr_u              addr;
    logic [`CSR_XLEN-1:0]   data;
  } csr_cmd_s;

  typedef struct packed {
    logic instr_misaligned;
    logic instr_access_fault;
    logic illegal_instr;
    logic ebreak;
    logic ecall;
    logic load_misaligned;
    logic load_access_fault;
    logic store_misaligned;
  } exc_s;

  typedef struct packed {
    logic [50:0] rsvd_63_13;
    priv_e       mpp;
    logic [2:0]  rsvd_10_8;
    logic        mpie;
    logic [2:0]  rsvd_6_4;
    logic        mie;
    logic [2:0]  rsvd_2_0;
  } mstatus_s;

  // mip and mie layout
  typedef struct packed {
    logic [51:0] rsvd_63_12;
    logic        mei;
    logic [2:0]  rsvd_10_8;
    logic        mti;
    logic [2:0]  rsvd_6_4;
    logic        msi;
    logic [2:0]  rsvd_2_0;
  } irq_bits_s;

  typedef struct packed {
    logic                     interrupt;
    logic [58:0]              rsvd;
    logic [`CSR_ECODE_W-1:0]  ecode;
  } mcause_s;

  typedef struct packed {
    logic                     v;
    logic                     interrupt;
    logic [`CSR_ECODE_W-1:0]  ecode;
  } trap_s;

  typedef struct packed {
    logic                     v;
    logic                     instret;
    logic [`CSR_VADDR_W-1:0]  pc;
    logic [`CSR_VADDR_W-1:0]  npc;
    priv_e                    priv_n;
    logic                     exception;
    logic                     interrupt;
    logic                     eret;
    logic [31:0]              instr;
  } commit_pkt_s;

endpackage

`default_nettype wire

// ==== logic/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Datapath widths
`define CSR_XLEN            64
`define CSR_VADDR_W         39
`define CSR_ECODE_W         4

// Core identity
`define CSR_BOOT_PC         39'h00_8000_0000
`define CSR_MARCHID         64'd7
`define CSR_MIMPID          64'd1
// RV64 with I, M and U
`define CSR_MISA_VAL        64'h8000_0000_0010_1100

// User counter views
`define CSR_ADDR_CYCLE         12'hC00
`define CSR_ADDR_INSTRET       12'hC02

// Machine trap setup
`define CSR_ADDR_MSTATUS       12'h300
`define CSR_ADDR_MISA          12'h301
`define CSR_ADDR_MIE           12'h304
`define CSR_ADDR_MTVEC         12'h305
`define CSR_ADDR_MCOUNTEREN    12'h306
`define CSR_ADDR_MCOUNTINHIBIT 12'h320

// Machine trap handling
`define CSR_ADDR_MSCRATCH      12'h340
`define CSR_ADDR_MEPC          12'h341
`define CSR_ADDR_MCAUSE        12'h342
`define CSR_ADDR_MTVAL         12'h343
`define CSR_ADDR_MIP           12'h344

// Machine counters
`define CSR_ADDR_MCYCLE        12'hB00
`define CSR_ADDR_MINSTRET      12'hB02

// Read-only identity registers
`define CSR_ADDR_MVENDORID     12'hF11
`define CSR_ADDR_MARCHID       12'hF12
`define CSR_ADDR_MIMPID        12'hF13
`define CSR_ADDR_MHARTID       12'hF14

`endif
